// File: rtl/axi_rd_pkg.sv
// AXI4 read-channel types and constants shared by the reader, the top level and the memory model
`default_nettype none

package axi_rd_pkg;

	// Channel payload widths
	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [7:0]  axi_len_t;
	typedef logic [1:0]  axi_resp_t;

	// Fixed AR sideband fields
	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_burst_t;
	typedef logic [3:0] axi_cache_t;
	typedef logic [2:0] axi_prot_t;
	typedef logic [3:0] axi_qos_t;

	localparam int AXI_BURST_LEN      = 16;
	localparam int AXI_BYTES_PER_BEAT = 4;

	localparam axi_size_t  AXI_SIZE_4B    = 3'd2;
	localparam axi_burst_t AXI_BURST_INCR = 2'b01;

endpackage

`default_nettype wire

// File: rtl/frame_reader_top.sv
// Frame reader top level, joins sequencer, line reader and line buffer behind AXI read and a pixel stream
`timescale 1ns/1ps
`default_nettype none

module frame_reader_top #(
	parameter int C_IMG_WBITS        = img_pkg::IMG_WBITS,
	parameter int C_WRITE_INDEX_BITS = img_pkg::LB_INDEX_BITS,
	parameter int C_M_AXI_BURST_LEN  = axi_rd_pkg::AXI_BURST_LEN
) (
	input  wire                        M_AXI_ACLK,
	input  wire                        M_AXI_ARESETN,

	// Software control and status
	input  wire                        start,
	input  wire                        soft_resetn,
	input  wire axi_rd_pkg::axi_addr_t frame_base,
	input  wire axi_rd_pkg::axi_addr_t line_stride,
	input  wire img_pkg::img_width_t   img_width,
	input  wire img_pkg::img_height_t  img_height,
	output logic                       busy,
	output logic                       resetting,

	// Pixel stream
	output logic                       pix_valid,
	output img_pkg::pixel_t            pix_data,
	output logic                       pix_eol,
	output logic                       pix_eof,
	input  wire                        pix_ready,

	// AXI4 read master
	output axi_rd_pkg::axi_addr_t      M_AXI_ARADDR,
	output axi_rd_pkg::axi_len_t       M_AXI_ARLEN,
	output axi_rd_pkg::axi_size_t      M_AXI_ARSIZE,
	output axi_rd_pkg::axi_burst_t     M_AXI_ARBURST,
	output logic                       M_AXI_ARLOCK,
	output axi_rd_pkg::axi_cache_t     M_AXI_ARCACHE,
	output axi_rd_pkg::axi_prot_t      M_AXI_ARPROT,
	output axi_rd_pkg::axi_qos_t       M_AXI_ARQOS,
	output logic                       M_AXI_ARVALID,
	input  wire                        M_AXI_ARREADY,
	input  wire axi_rd_pkg::axi_data_t M_AXI_RDATA,
	input  wire axi_rd_pkg::axi_resp_t M_AXI_RRESP,
	input  wire                        M_AXI_RLAST,
	input  wire                        M_AXI_RVALID,
	output logic                       M_AXI_RREADY
);

	import axi_rd_pkg::*;
	import img_pkg::*;

	// Sequencer to reader
	logic      sol;
	axi_addr_t line_addr;
	logic      end_of_line_pulse;

	// Reader to buffer write port
	logic      wr_en;
	lb_index_t wr_addr;
	axi_data_t wr_data;

	// Sequencer to buffer drain control
	logic      drain_start;
	lb_index_t drain_words;
	logic      drain_last_line;
	logic      drain_done;

	frame_sequencer #(
		.C_IMG_WBITS (C_IMG_WBITS)
	) frame_sequencer_inst (.*);

	line_reader #(
		.C_IMG_WBITS        (C_IMG_WBITS),
		.C_WRITE_INDEX_BITS (C_WRITE_INDEX_BITS),
		.C_M_AXI_BURST_LEN  (C_M_AXI_BURST_LEN)
	) line_reader_inst (.*);

	line_buffer #(
		.C_WRITE_INDEX_BITS (C_WRITE_INDEX_BITS)
	) line_buffer_inst (.*);

endmodule

`default_nettype wire

// File: rtl/frame_sequencer.sv
// Frame-level line sequencer, steps line addresses and hands each line from fetch to drain
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer #(
	parameter int C_IMG_WBITS = 12
) (
	input  wire                        M_AXI_ACLK,
	input  wire                        M_AXI_ARESETN,
	input  wire                        soft_resetn,
	input  wire                        start,

	input  wire axi_rd_pkg::axi_addr_t frame_base,
	input  wire axi_rd_pkg::axi_addr_t line_stride,
	input  wire img_pkg::img_width_t   img_width,
	input  wire img_pkg::img_height_t  img_height,

	output logic                       sol,
	output axi_rd_pkg::axi_addr_t      line_addr,
	input  wire                        end_of_line_pulse,

	output logic                       drain_start,
	output img_pkg::lb_index_t         drain_words,
	output logic                       drain_last_line,
	input  wire                        drain_done,

	output logic                       busy
);

	import img_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DRAIN,
		NEXT
	} seq_state_t;

	seq_state_t             state;
	logic [C_IMG_WBITS-1:0] line_cnt;
	logic                   last_line;

	assign last_line   = (line_cnt + 1'b1) == img_height;
	assign drain_words = lb_index_t'(img_width >> $clog2(PIXELS_PER_WORD));
	// NEXT lasts one cycle and is the start-of-line pulse
	assign sol         = (state == NEXT);
	assign busy        = (state != IDLE);

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || !soft_resetn) begin
			state           <= IDLE;
			line_cnt        <= '0;
			drain_start     <= 1'b0;
			drain_last_line <= 1'b0;
		end else begin
			drain_start <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						line_cnt <= '0;
						state    <= NEXT;
					end
				end
				NEXT: begin
					state <= FETCH;
				end
				FETCH: begin
					if (end_of_line_pulse) begin
						drain_start     <= 1'b1;
						drain_last_line <= last_line;
						state           <= DRAIN;
					end
				end
				DRAIN: begin
					if (drain_done) begin
						if (drain_last_line) begin
							state <= IDLE;
						end else begin
							line_cnt <= line_cnt + 1'b1;
							state    <= NEXT;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Line address, held stable between steps
	always_ff @(posedge M_AXI_ACLK) begin
		if (state == IDLE && start) begin
			line_addr <= frame_base;
		end else if (state == DRAIN && drain_done && !drain_last_line) begin
			line_addr <= line_addr + line_stride;
		end
	end

endmodule

`default_nettype wire

// File: rtl/img_pkg.sv
// Pixel, image-dimension and line-buffer index types used by the frame reader blocks
`default_nettype none

package img_pkg;

	localparam int IMG_WBITS     = 12;
	localparam int LB_INDEX_BITS = 10;

	typedef logic [7:0] pixel_t;

	// Image dimensions
	typedef logic [IMG_WBITS-1:0] img_width_t;
	typedef logic [IMG_WBITS-1:0] img_height_t;

	// One line-buffer entry holds one bus word
	typedef logic [LB_INDEX_BITS-1:0] lb_index_t;

	// Equals data width over pixel width
	localparam int PIXELS_PER_WORD = 2 ** (IMG_WBITS - LB_INDEX_BITS);

endpackage

`default_nettype wire

// File: rtl/line_buffer.sv
// Single-line word RAM with a pixel unpacker, drained as a valid/ready pixel stream
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
	parameter int C_WRITE_INDEX_BITS = 10
) (
	input  wire                        M_AXI_ACLK,
	input  wire                        M_AXI_ARESETN,
	input  wire                        soft_resetn,

	input  wire                        wr_en,
	input  wire img_pkg::lb_index_t    wr_addr,
	input  wire axi_rd_pkg::axi_data_t wr_data,

	input  wire                        drain_start,
	input  wire img_pkg::lb_index_t    drain_words,
	input  wire                        drain_last_line,
	output logic                       drain_done,

	output logic                       pix_valid,
	output img_pkg::pixel_t            pix_data,
	output logic                       pix_eol,
	output logic                       pix_eof,
	input  wire                        pix_ready
);

	import axi_rd_pkg::*;
	import img_pkg::*;

	localparam int DEPTH    = 2 ** C_WRITE_INDEX_BITS;
	localparam int SEL_BITS = $clog2(PIXELS_PER_WORD);
	localparam logic [SEL_BITS-1:0] LAST_SEL = SEL_BITS'(PIXELS_PER_WORD - 1);

	axi_data_t                     mem [DEPTH];
	axi_data_t                     rd_word;
	logic [C_WRITE_INDEX_BITS-1:0] rd_idx;
	lb_index_t                     words_left;
	logic [SEL_BITS-1:0]           pix_sel;
	logic                          last_line_q;
	logic                          pix_take;
	logic                          rd_fire;

	assign pix_take = pix_valid && pix_ready;
	// Fetch the next word when the output is empty or its last pixel leaves
	assign rd_fire  = (words_left != '0) && (!pix_valid || (pix_take && pix_sel == LAST_SEL));

	// Least significant byte goes out first
	assign pix_data = rd_word[pix_sel*$bits(pixel_t) +: $bits(pixel_t)];
	assign pix_eol  = pix_valid && (words_left == '0) && (pix_sel == LAST_SEL);
	assign pix_eof  = pix_eol && last_line_q;

	always_ff @(posedge M_AXI_ACLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (rd_fire) begin
			rd_word <= mem[rd_idx];
		end
	end

	// ----------------------------------------------------------------------
	// Drain control
	// ----------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || !soft_resetn) begin
			rd_idx      <= '0;
			words_left  <= '0;
			pix_sel     <= '0;
			pix_valid   <= 1'b0;
			last_line_q <= 1'b0;
			drain_done  <= 1'b0;
		end else begin
			drain_done <= pix_take && pix_eol;
			if (drain_start) begin
				rd_idx      <= '0;
				words_left  <= drain_words;
				last_line_q <= drain_last_line;
			end else if (rd_fire) begin
				rd_idx     <= rd_idx + 1'b1;
				words_left <= words_left - 1'b1;
				pix_sel    <= '0;
				pix_valid  <= 1'b1;
			end else if (pix_take) begin
				if (pix_sel == LAST_SEL) begin
					pix_valid <= 1'b0;
				end else begin
					pix_sel <= pix_sel + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/line_reader.sv
// AXI4 burst read master, fetches one image line per start-of-line into the line buffer
`timescale 1ns/1ps
`default_nettype none

module line_reader #(
	parameter int C_IMG_WBITS        = 12,
	parameter int C_WRITE_INDEX_BITS = 10,
	parameter int C_M_AXI_BURST_LEN  = 16
) (
	input  wire                        M_AXI_ACLK,
	input  wire                        M_AXI_ARESETN,
	input  wire                        soft_resetn,
	output logic                       resetting,

	input  wire img_pkg::img_width_t   img_width,

	input  wire                        sol,
	input  wire axi_rd_pkg::axi_addr_t line_addr,
	output logic                       end_of_line_pulse,

	output axi_rd_pkg::axi_data_t      wr_data,
	output img_pkg::lb_index_t         wr_addr,
	output logic                       wr_en,

	output axi_rd_pkg::axi_addr_t      M_AXI_ARADDR,
	output axi_rd_pkg::axi_len_t       M_AXI_ARLEN,
	output axi_rd_pkg::axi_size_t      M_AXI_ARSIZE,
	output axi_rd_pkg::axi_burst_t     M_AXI_ARBURST,
	output logic                       M_AXI_ARLOCK,
	output axi_rd_pkg::axi_cache_t     M_AXI_ARCACHE,
	output axi_rd_pkg::axi_prot_t      M_AXI_ARPROT,
	output axi_rd_pkg::axi_qos_t       M_AXI_ARQOS,
	output logic                       M_AXI_ARVALID,
	input  wire                        M_AXI_ARREADY,

	input  wire axi_rd_pkg::axi_data_t M_AXI_RDATA,
	input  wire axi_rd_pkg::axi_resp_t M_AXI_RRESP,
	input  wire                        M_AXI_RLAST,
	input  wire                        M_AXI_RVALID,
	output logic                       M_AXI_RREADY
);

	import axi_rd_pkg::*;
	import img_pkg::*;

	// Shift from a pixel count to a word count
	localparam int PIX_SHIFT = C_IMG_WBITS - C_WRITE_INDEX_BITS;
	localparam logic [C_IMG_WBITS-1:0] WORD_PIX = C_IMG_WBITS'(PIXELS_PER_WORD);
	localparam logic [C_IMG_WBITS-1:0] FULL_BURST_PIX =
		C_IMG_WBITS'(C_M_AXI_BURST_LEN * PIXELS_PER_WORD);
	localparam axi_addr_t BURST_BYTES = axi_addr_t'(C_M_AXI_BURST_LEN * AXI_BYTES_PER_BEAT);
	localparam axi_len_t  FULL_LEN    = axi_len_t'(C_M_AXI_BURST_LEN - 1);

	axi_addr_t                     araddr_q;
	axi_len_t                      arlen_q;
	logic                          arvalid_q;
	logic                          burst_active;
	logic                          rnext;
	logic                          burst_done;
	logic                          start_burst;
	logic                          sol_d1;
	logic                          lining;
	logic                          eol_q;
	logic                          soft_resetn_d1;
	logic                          resetting_q;
	logic [C_IMG_WBITS-1:0]        cols_left;
	logic [C_IMG_WBITS-1:0]        tail_words;
	logic [C_WRITE_INDEX_BITS-1:0] wr_idx;

	assign rnext       = M_AXI_RVALID && M_AXI_RREADY;
	assign burst_done  = rnext && M_AXI_RLAST;
	assign tail_words  = cols_left >> PIX_SHIFT;
	// Next burst once the previous one has fully returned
	assign start_burst = lining && !burst_active && (cols_left != '0) && soft_resetn;

	// Beats of an aborted line are dropped, response codes are not inspected
	assign wr_data = M_AXI_RDATA;
	assign wr_addr = wr_idx;
	assign wr_en   = rnext && soft_resetn && !resetting_q;

	assign M_AXI_ARADDR  = araddr_q;
	assign M_AXI_ARLEN   = arlen_q;
	assign M_AXI_ARSIZE  = AXI_SIZE_4B;
	assign M_AXI_ARBURST = AXI_BURST_INCR;
	assign M_AXI_ARLOCK  = 1'b0;
	assign M_AXI_ARCACHE = '0;
	assign M_AXI_ARPROT  = '0;
	assign M_AXI_ARQOS   = '0;
	assign M_AXI_ARVALID = arvalid_q;
	assign M_AXI_RREADY  = burst_active;

	assign resetting         = resetting_q;
	assign end_of_line_pulse = eol_q;

	// ----------------------------------------------------------------------
	// Soft reset tracking
	// ----------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			soft_resetn_d1 <= 1'b0;
		end else begin
			soft_resetn_d1 <= soft_resetn;
		end
	end

	// Held while an open burst drains after an abort
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			resetting_q <= 1'b1;
		end else if (!burst_active || burst_done) begin
			resetting_q <= 1'b0;
		end else if (soft_resetn_d1 && !soft_resetn) begin
			resetting_q <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Read address channel
	// ----------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			arvalid_q    <= 1'b0;
			burst_active <= 1'b0;
		end else begin
			if (start_burst) begin
				arvalid_q <= 1'b1;
			end else if (M_AXI_ARREADY) begin
				arvalid_q <= 1'b0;
			end
			if (start_burst) begin
				burst_active <= 1'b1;
			end else if (burst_done) begin
				burst_active <= 1'b0;
			end
		end
	end

	// Only the last burst of a line can be short
	always_ff @(posedge M_AXI_ACLK) begin
		if (sol) begin
			araddr_q <= line_addr;
		end else if (burst_done) begin
			araddr_q <= araddr_q + BURST_BYTES;
		end
		if (start_burst) begin
			if (cols_left >= FULL_BURST_PIX) begin
				arlen_q <= FULL_LEN;
			end else begin
				arlen_q <= axi_len_t'(tail_words - 1'b1);
			end
		end
	end

	// ----------------------------------------------------------------------
	// Line progress
	// ----------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN || !soft_resetn) begin
			cols_left <= '0;
			sol_d1    <= 1'b0;
		end else begin
			sol_d1 <= sol;
			if (sol) begin
				cols_left <= img_width;
			end else if (rnext && cols_left != '0) begin
				cols_left <= cols_left - WORD_PIX;
			end
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_idx <= '0;
		end else if (sol) begin
			wr_idx <= '0;
		end else if (rnext) begin
			wr_idx <= wr_idx + 1'b1;
		end
	end

	// Line ends when nothing is left and no burst is open
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			lining <= 1'b0;
			eol_q  <= 1'b0;
		end else begin
			eol_q <= lining && !burst_active && (cols_left == '0);
			if (sol_d1) begin
				lining <= 1'b1;
			end else if (!burst_active && cols_left == '0) begin
				lining <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_frame_reader -f sources.f \
	-o tb_frame_reader &&
./obj_dir/tb_frame_reader || exit 1

// File: sim/axi_mem_model.sv
// Behavioral AXI4 read slave for the testbench with address-derived data and random stalls
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
	input  wire                         M_AXI_ACLK,
	input  wire                         M_AXI_ARESETN,
	input  wire axi_rd_pkg::axi_addr_t  M_AXI_ARADDR,
	input  wire axi_rd_pkg::axi_len_t   M_AXI_ARLEN,
	input  wire axi_rd_pkg::axi_size_t  M_AXI_ARSIZE,
	input  wire axi_rd_pkg::axi_burst_t M_AXI_ARBURST,
	input  wire                         M_AXI_ARLOCK,
	input  wire axi_rd_pkg::axi_cache_t M_AXI_ARCACHE,
	input  wire axi_rd_pkg::axi_prot_t  M_AXI_ARPROT,
	input  wire axi_rd_pkg::axi_qos_t   M_AXI_ARQOS,
	input  wire                         M_AXI_ARVALID,
	output logic                        M_AXI_ARREADY,
	output axi_rd_pkg::axi_data_t       M_AXI_RDATA,
	output axi_rd_pkg::axi_resp_t       M_AXI_RRESP,
	output logic                        M_AXI_RLAST,
	output logic                        M_AXI_RVALID,
	input  wire                         M_AXI_RREADY,
	output logic                        protocol_error
);

	import axi_rd_pkg::*;

	logic [31:0] lcg;
	logic        open_q;
	axi_addr_t   base_q;
	axi_len_t    len_q;
	logic [8:0]  issued;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte at address a is a[7:0] xor a[15:8]
	function automatic logic [7:0] byte_at(input axi_addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	function automatic axi_data_t word_at(input axi_addr_t a);
		return {byte_at(a + 32'd3), byte_at(a + 32'd2), byte_at(a + 32'd1), byte_at(a)};
	endfunction

	// Every response is OKAY
	assign M_AXI_RRESP = '0;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			lcg            <= 32'h221a;
			open_q         <= 1'b0;
			issued         <= '0;
			M_AXI_ARREADY  <= 1'b0;
			M_AXI_RVALID   <= 1'b0;
			M_AXI_RLAST    <= 1'b0;
			M_AXI_RDATA    <= '0;
			protocol_error <= 1'b0;
		end else begin
			lcg <= lcg_next(lcg);

			// The master may not request while its previous burst is open
			if (M_AXI_ARVALID && open_q) begin
				$display("AXI model: read request at %h while a burst is open", M_AXI_ARADDR);
				protocol_error <= 1'b1;
			end

			// One burst is open at a time on the address channel
			if (M_AXI_ARVALID && M_AXI_ARREADY) begin
				if (M_AXI_ARADDR[1:0] != 2'b00 || M_AXI_ARSIZE != AXI_SIZE_4B ||
						M_AXI_ARBURST != AXI_BURST_INCR || M_AXI_ARLOCK != 1'b0 ||
						M_AXI_ARCACHE != '0 || M_AXI_ARPROT != '0 || M_AXI_ARQOS != '0) begin
					$display("AXI model: malformed read request at address %h", M_AXI_ARADDR);
					protocol_error <= 1'b1;
				end
				open_q        <= 1'b1;
				base_q        <= M_AXI_ARADDR;
				len_q         <= M_AXI_ARLEN;
				issued        <= '0;
				M_AXI_ARREADY <= 1'b0;
			end else begin
				M_AXI_ARREADY <= M_AXI_ARVALID && !open_q && lcg[16];
			end

			// A presented data beat is held until it is taken
			if (M_AXI_RVALID && M_AXI_RREADY && M_AXI_RLAST) begin
				open_q <= 1'b0;
			end
			if (!M_AXI_RVALID || M_AXI_RREADY) begin
				if (open_q && issued <= {1'b0, len_q} && lcg[21:20] != 2'b00) begin
					M_AXI_RVALID <= 1'b1;
					M_AXI_RDATA  <= word_at(base_q + axi_addr_t'({issued, 2'b00}));
					M_AXI_RLAST  <= (issued == {1'b0, len_q});
					issued       <= issued + 1'b1;
				end else begin
					M_AXI_RVALID <= 1'b0;
					M_AXI_RLAST  <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_frame_reader.sv
// Frame reader testbench that applies a table of frames and checks every pixel and read request
`timescale 1ns/1ps
`default_nettype none

module tb_frame_reader;

	import axi_rd_pkg::*;
	import img_pkg::*;

	localparam int NUM_ROWS  = 5;
	localparam int BURST_LEN = 4;

	// Per row the frame base, line stride, width, height, random ready and abort kind
	localparam axi_addr_t ROW_BASE [NUM_ROWS] = '{
		32'h0000_1000, 32'h0002_0340, 32'h0001_2000, 32'h0000_3a00, 32'h0005_0000
	};
	localparam axi_addr_t ROW_STRIDE [NUM_ROWS] = '{
		32'h100, 32'h80, 32'h200, 32'h40, 32'h400
	};
	localparam int ROW_WIDTH  [NUM_ROWS] = '{32, 20, 24, 44, 12};
	localparam int ROW_HEIGHT [NUM_ROWS] = '{3, 4, 5, 3, 2};
	localparam int ROW_RANDOM [NUM_ROWS] = '{0, 1, 1, 1, 0};
	// Abort kind 1 hits the first burst of line 1 and kind 2 its first pixel
	localparam int ROW_ABORT  [NUM_ROWS] = '{2, 0, 1, 0, 0};

	logic        M_AXI_ACLK;
	logic        M_AXI_ARESETN;
	logic        start;
	logic        soft_resetn;
	axi_addr_t   frame_base;
	axi_addr_t   line_stride;
	img_width_t  img_width;
	img_height_t img_height;
	logic        busy;
	logic        resetting;
	logic        pix_valid;
	pixel_t      pix_data;
	logic        pix_eol;
	logic        pix_eof;
	logic        pix_ready;
	axi_addr_t   M_AXI_ARADDR;
	axi_len_t    M_AXI_ARLEN;
	axi_size_t   M_AXI_ARSIZE;
	axi_burst_t  M_AXI_ARBURST;
	logic        M_AXI_ARLOCK;
	axi_cache_t  M_AXI_ARCACHE;
	axi_prot_t   M_AXI_ARPROT;
	axi_qos_t    M_AXI_ARQOS;
	logic        M_AXI_ARVALID;
	logic        M_AXI_ARREADY;
	axi_data_t   M_AXI_RDATA;
	axi_resp_t   M_AXI_RRESP;
	logic        M_AXI_RLAST;
	logic        M_AXI_RVALID;
	logic        M_AXI_RREADY;
	logic        protocol_error;
	logic [31:0] rand_state;

	frame_reader_top #(
		.C_M_AXI_BURST_LEN (BURST_LEN)
	) frame_reader_top_inst (.*);

	axi_mem_model axi_mem_model_inst (.*);

	initial begin
		M_AXI_ACLK = 1'b0;
		forever #4 M_AXI_ACLK = ~M_AXI_ACLK;
	end

	// ----------------------------------------------------------------------
	// Helpers and compare tasks
	// ----------------------------------------------------------------------

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		if (got !== exp) begin
			fail_now($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_now($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_addr(input axi_addr_t got, input axi_addr_t exp, input string what);
		if (got !== exp) begin
			fail_now($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_len(input axi_len_t got, input axi_len_t exp, input string what);
		if (got !== exp) begin
			fail_now($sformatf("Fail at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte at address a is a[7:0] xor a[15:8]
	function automatic pixel_t expected_pixel(input axi_addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	// ----------------------------------------------------------------------
	// Frame run and abort
	// ----------------------------------------------------------------------

	task automatic abort_frame(input logic burst_open);
		soft_resetn = 1'b0;
		@(negedge M_AXI_ACLK);
		check_flag(pix_valid, 1'b0, "pix_valid after soft reset");
		check_flag(busy, 1'b0, "busy after soft reset");
		check_flag(resetting, burst_open, "resetting after soft reset");
		soft_resetn = 1'b1;
		// The open burst keeps RREADY high until its last beat
		while (resetting) begin
			check_flag(M_AXI_RREADY, 1'b1, "RREADY while resetting");
			check_flag(M_AXI_ARVALID, 1'b0, "ARVALID while resetting");
			@(negedge M_AXI_ACLK);
		end
		check_flag(M_AXI_RREADY, 1'b0, "RREADY after resetting");
		// Nothing may start on its own before the next frame
		repeat (10) begin
			check_flag(M_AXI_ARVALID, 1'b0, "ARVALID after abort");
			check_flag(busy, 1'b0, "busy after abort");
			check_flag(pix_valid, 1'b0, "pix_valid after abort");
			@(negedge M_AXI_ACLK);
		end
	endtask

	task automatic run_frame(input int r);
		int        words;
		int        burst;
		int        ar_line;
		int        ar_beats;
		int        pix_line;
		int        pix_idx;
		logic      last_seen;
		logic      abort_go;
		axi_addr_t pix_addr;

		check_flag(busy, 1'b0, "busy before start");
		frame_base  = ROW_BASE[r];
		line_stride = ROW_STRIDE[r];
		img_width   = img_width_t'(ROW_WIDTH[r]);
		img_height  = img_height_t'(ROW_HEIGHT[r]);
		start       = 1'b1;
		@(negedge M_AXI_ACLK);
		start = 1'b0;
		check_flag(busy, 1'b1, "busy after start");
		words     = ROW_WIDTH[r] / PIXELS_PER_WORD;
		ar_line   = 0;
		ar_beats  = 0;
		pix_line  = 0;
		pix_idx   = 0;
		last_seen = 1'b0;
		abort_go  = 1'b0;
		while (!(last_seen && !busy)) begin
			// AR handshake completes on the coming rising edge
			if (M_AXI_ARVALID && M_AXI_ARREADY) begin
				if (ar_line >= ROW_HEIGHT[r]) begin
					fail_now("Read request issued after the last line of the frame");
				end
				burst = (words - ar_beats < BURST_LEN) ? words - ar_beats : BURST_LEN;
				check_addr(M_AXI_ARADDR, ROW_BASE[r] + axi_addr_t'(ar_line) * ROW_STRIDE[r] +
					axi_addr_t'(ar_beats * AXI_BYTES_PER_BEAT), "ARADDR");
				check_len(M_AXI_ARLEN, axi_len_t'(burst - 1), "ARLEN");
				abort_go = (ROW_ABORT[r] == 1) && ar_line == 1 && ar_beats == 0;
				ar_beats += burst;
				if (ar_beats == words) begin
					ar_line++;
					ar_beats = 0;
				end
			end
			rand_state = lcg_next(rand_state);
			pix_ready  = (ROW_RANDOM[r] != 0) ? rand_state[16] : 1'b1;
			if (pix_valid && pix_ready) begin
				if (last_seen) begin
					fail_now("Pixel accepted after the end of the frame");
				end
				pix_addr = ROW_BASE[r] + axi_addr_t'(pix_line) * ROW_STRIDE[r] +
					axi_addr_t'(pix_idx);
				check_pixel(pix_data, expected_pixel(pix_addr), "pixel data");
				check_flag(pix_eol, pix_idx == ROW_WIDTH[r] - 1, "pix_eol");
				check_flag(pix_eof, pix_idx == ROW_WIDTH[r] - 1 && pix_line == ROW_HEIGHT[r] - 1,
					"pix_eof");
				if (pix_eof) begin
					check_flag(busy, 1'b1, "busy on the last pixel");
					last_seen = 1'b1;
				end
				// The rest of line 1 is still waiting in the buffer
				if (ROW_ABORT[r] == 2 && pix_line == 1 && pix_idx == 0) begin
					abort_go = 1'b1;
				end
				pix_idx++;
				if (pix_idx == ROW_WIDTH[r]) begin
					pix_idx = 0;
					pix_line++;
				end
			end
			@(negedge M_AXI_ACLK);
			if (abort_go) begin
				break;
			end
		end
		if (abort_go) begin
			abort_frame(ROW_ABORT[r] == 1);
		end
	endtask

	// ----------------------------------------------------------------------
	// Main sequence, watchdog and model monitor
	// ----------------------------------------------------------------------

	initial begin
		M_AXI_ARESETN = 1'b0;
		start         = 1'b0;
		soft_resetn   = 1'b1;
		frame_base    = '0;
		line_stride   = '0;
		img_width     = '0;
		img_height    = '0;
		pix_ready     = 1'b0;
		rand_state    = 32'h221a;
		repeat (3) @(negedge M_AXI_ACLK);
		M_AXI_ARESETN = 1'b1;
		check_flag(resetting, 1'b1, "resetting in the first cycle after reset");
		@(negedge M_AXI_ACLK);
		check_flag(resetting, 1'b0, "resetting after reset");
		check_flag(M_AXI_ARVALID, 1'b0, "ARVALID after reset");
		check_flag(M_AXI_RREADY, 1'b0, "RREADY after reset");
		check_flag(pix_valid, 1'b0, "pix_valid after reset");
		check_flag(busy, 1'b0, "busy after reset");
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_frame(r);
		end
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin
		longint limit_ns;
		limit_ns = 10000;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit_ns += longint'(ROW_WIDTH[r] * ROW_HEIGHT[r] * 40);
		end
		#(limit_ns);
		fail_now("Timeout: the frame reader did not finish within the time limit");
	end

	initial begin
		wait (protocol_error === 1'b1);
		fail_now("The AXI memory model saw a protocol violation");
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/axi_rd_pkg.sv
rtl/img_pkg.sv
rtl/line_reader.sv
rtl/line_buffer.sv
rtl/frame_sequencer.sv
rtl/frame_reader_top.sv
sim/axi_mem_model.sv
sim/tb_frame_reader.sv
